/* logic/tmc_proto_pkg.sv */
package tmc_proto_pkg;

	// ********************
	// Datagram operations
	// ********************

	// Two bits wide so that undefined codes can reach the engine and be rejected.
	typedef enum logic [1:0] {
		TMC_OP_WRITE = 2'd1,
		TMC_OP_READ  = 2'd2
	} tmc_op_t;

	typedef enum logic [2:0] {
		ST_OK          = 3'd0,
		ST_TIMEOUT     = 3'd1,
		ST_SYNC        = 3'd2, // Low nibble of the first reply byte is wrong.
		ST_MASTER_ADDR = 3'd3,
		ST_REGISTER    = 3'd4,
		ST_CRC         = 3'd5,
		ST_BAD_OP      = 3'd6
	} tmc_status_t;

	// ********************
	// Datagram constants
	// ********************

	localparam logic [7:0] TMC_SYNC        = 8'h05; // Sync plus reserved bits.
	localparam logic [7:0] TMC_MASTER_ADDR = 8'hff; // Address the driver uses in its reply.
	localparam logic [7:0] TMC_CRC_POLY    = 8'h07; // x^8 + x^2 + x + 1.

endpackage

/* logic/uart_line_pkg.sv */
package uart_line_pkg;

	// One character on the wire.
	typedef logic [7:0] uart_byte_t;

	// Width of a channel index for n channels, never below one bit.
	function automatic int chan_bits(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

/* logic/byte_stream_if.sv */
`timescale 1ns/1ps

// Byte stream with valid/ready flow control.
// A byte moves on a clock edge where both valid and ready are high.
interface byte_stream_if;
	import uart_line_pkg::*;

	uart_byte_t data;
	logic last; // Marks the CRC byte, the final byte of a datagram.
	logic valid;
	logic ready;

	modport source (output data, output last, output valid, input ready);
	modport sink (input data, input last, input valid, output ready);

endinterface

/* logic/tmc_datagram_ctrl.sv */
`timescale 1ns/1ps

module tmc_datagram_ctrl #(
	parameter int NUART = 4,
	parameter int BIT_CYCLES = 8,
	parameter int RX_TIMEOUT_BITS = 700,
	localparam int CH_W = uart_line_pkg::chan_bits(NUART)
) (
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	output logic cmd_ready,
	input tmc_proto_pkg::tmc_op_t cmd_op,
	input logic [CH_W-1:0] cmd_channel,
	input uart_line_pkg::uart_byte_t cmd_slave,
	input logic [6:0] cmd_register,
	input logic [31:0] cmd_data,
	output logic rsp_valid,
	input logic rsp_ready,
	output logic [CH_W-1:0] rsp_channel,
	output tmc_proto_pkg::tmc_status_t rsp_status,
	output logic [31:0] rsp_data,
	byte_stream_if.source tx,
	input uart_line_pkg::uart_byte_t rx_byte,
	input logic rx_valid,
	input logic tx_done,
	output logic [CH_W-1:0] channel,
	output logic listen
);
	import tmc_proto_pkg::*;
	import uart_line_pkg::*;

	localparam int TIMEOUT_CYCLES = RX_TIMEOUT_BITS * BIT_CYCLES;
	localparam int GUARD_CYCLES = 8 * BIT_CYCLES;
	localparam int DLY_MAX = (TIMEOUT_CYCLES > GUARD_CYCLES) ? TIMEOUT_CYCLES : GUARD_CYCLES;
	localparam int DLY_W = $clog2(DLY_MAX + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_SEND,    // Push datagram bytes into the FIFO.
		S_WAIT_TX, // Wait for the stop bit of the CRC byte.
		S_TURN,    // Two bit times before the line is released.
		S_RECV,
		S_DRAIN,   // Reply rejected, let the line go quiet.
		S_RESP,
		S_GUARD
	} state_t;

	state_t state;
	logic is_write;
	uart_byte_t slave_q;
	logic [6:0] reg_q;
	logic [31:0] data_q;
	tmc_status_t status_q;
	uart_byte_t crc;
	logic [2:0] byte_idx; // Byte position, shared by the send and receive phases.
	logic [2:0] last_idx;
	uart_byte_t frame_byte;
	logic [DLY_W-1:0] delay;
	uart_byte_t tx_data_q;
	logic tx_last_q;
	logic tx_valid_q;

	// CRC-8 over one byte, data bits taken LSB first.
	function automatic uart_byte_t crc8(input uart_byte_t crc_in, input uart_byte_t b);
		uart_byte_t c;
		int i;
		c = crc_in;
		for (i = 0; i < 8; i++) begin
			if (c[7] ^ b[i])
				c = {c[6:0], 1'b0} ^ TMC_CRC_POLY;
			else
				c = {c[6:0], 1'b0};
		end
		return c;
	endfunction

	// A read stops after the register byte, a write carries four data bytes.
	assign last_idx = is_write ? 3'd7 : 3'd3;

	always_comb begin
		case (byte_idx)
			3'd0: frame_byte = TMC_SYNC;
			3'd1: frame_byte = slave_q;
			3'd2: frame_byte = {is_write, reg_q};
			3'd3: frame_byte = data_q[31:24];
			3'd4: frame_byte = data_q[23:16];
			3'd5: frame_byte = data_q[15:8];
			default: frame_byte = data_q[7:0];
		endcase
	end

	assign cmd_ready = (state == S_IDLE);
	assign rsp_valid = (state == S_RESP);
	assign rsp_channel = channel;
	assign rsp_status = status_q;
	assign rsp_data = data_q;

	assign tx.data = tx_data_q;
	assign tx.last = tx_last_q;
	assign tx.valid = tx_valid_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			tx_valid_q <= 1'b0;
			listen <= 1'b0;
			channel <= '0;
			delay <= '0;
		end else begin
			// The state machine below may reload the counter.
			if (delay != '0)
				delay <= delay - 1'b1;
			if (tx_valid_q && tx.ready)
				tx_valid_q <= 1'b0;

			case (state)
				S_IDLE: if (cmd_valid) begin
					channel <= cmd_channel;
					slave_q <= cmd_slave;
					reg_q <= cmd_register;
					data_q <= cmd_data;
					is_write <= (cmd_op == TMC_OP_WRITE);
					byte_idx <= '0;
					crc <= '0;
					if (cmd_op == TMC_OP_WRITE || cmd_op == TMC_OP_READ) begin
						state <= S_SEND;
					end else begin
						status_q <= ST_BAD_OP; // Nothing goes out on the line.
						state <= S_RESP;
					end
				end
				S_SEND: if (!tx_valid_q || tx.ready) begin
					tx_valid_q <= 1'b1;
					if (byte_idx == last_idx) begin
						tx_data_q <= crc;
						tx_last_q <= 1'b1;
						state <= S_WAIT_TX;
					end else begin
						tx_data_q <= frame_byte;
						tx_last_q <= 1'b0;
						crc <= crc8(crc, frame_byte);
						byte_idx <= byte_idx + 1'b1;
					end
				end
				S_WAIT_TX: if (tx_done) begin
					if (is_write) begin
						status_q <= ST_OK;
						state <= S_RESP;
					end else begin
						delay <= DLY_W'(2 * BIT_CYCLES - 2);
						state <= S_TURN;
					end
				end
				S_TURN: if (delay == '0) begin
					listen <= 1'b1; // Hand the wire to the driver.
					crc <= '0;
					byte_idx <= '0;
					data_q <= '0;
					delay <= DLY_W'(TIMEOUT_CYCLES - 1);
					state <= S_RECV;
				end
				S_RECV: if (rx_valid) begin
					byte_idx <= byte_idx + 1'b1;
					crc <= crc8(crc, rx_byte);
					case (byte_idx)
						3'd0: if (rx_byte[3:0] != TMC_SYNC[3:0]) begin
							status_q <= ST_SYNC;
							state <= S_DRAIN;
						end
						3'd1: if (rx_byte != TMC_MASTER_ADDR) begin
							status_q <= ST_MASTER_ADDR;
							state <= S_DRAIN;
						end
						3'd2: if (rx_byte != {1'b0, reg_q}) begin
							status_q <= ST_REGISTER;
							state <= S_DRAIN;
						end
						3'd7: begin
							status_q <= (rx_byte == crc) ? ST_OK : ST_CRC;
							state <= (rx_byte == crc) ? S_RESP : S_DRAIN;
						end
						default: data_q <= {data_q[23:0], rx_byte}; // Big-endian.
					endcase
				end else if (delay == '0) begin
					status_q <= ST_TIMEOUT;
					state <= S_RESP;
				end
				S_DRAIN: if (delay == '0)
					state <= S_RESP;
				S_RESP: if (rsp_ready) begin
					delay <= DLY_W'(GUARD_CYCLES - 1);
					state <= S_GUARD;
				end
				S_GUARD: if (delay == '0) begin
					listen <= 1'b0;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* logic/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst_n,
	byte_stream_if.sink in_s,
	byte_stream_if.source out_s
);
	import uart_line_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	uart_byte_t mem_data [FIFO_DEPTH];
	logic mem_last [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count; // One extra bit so a full FIFO can be told from an empty one.
	logic full;
	logic empty;
	logic push;
	logic pop;

	assign full = (count == (PTR_W + 1)'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign push = in_s.valid && in_s.ready;
	assign pop = out_s.valid && out_s.ready;

	assign in_s.ready = !full;
	assign out_s.valid = !empty;
	assign out_s.data = mem_data[rd_ptr];
	assign out_s.last = mem_last[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem_data[wr_ptr] <= in_s.data;
			mem_last[wr_ptr] <= in_s.last;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

/* logic/uart_line.sv */
`timescale 1ns/1ps

module uart_line #(
	parameter int NUART = 4,
	parameter int BIT_CYCLES = 8,
	localparam int CH_W = uart_line_pkg::chan_bits(NUART)
) (
	input logic clk,
	input logic rst_n,
	byte_stream_if.sink tx,
	input logic [CH_W-1:0] channel,
	input logic listen,
	output uart_line_pkg::uart_byte_t rx_byte,
	output logic rx_valid,
	output logic tx_done,
	input logic [NUART-1:0] uart_in,
	output logic [NUART-1:0] uart_out,
	output logic [NUART-1:0] uart_en
);
	import uart_line_pkg::*;

	localparam int CYC_W = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;
	localparam int HALF = BIT_CYCLES / 2;

	logic tx_busy;
	logic [9:0] tx_shift; // Stop bit, data LSB first, start bit.
	logic [3:0] tx_bit;
	logic [CYC_W-1:0] tx_cyc;
	logic tx_last_q;
	logic tx_bit_end;
	logic tx_frame_end;

	logic rx_in;
	logic [1:0] rx_sync;
	logic rx_busy;
	logic [3:0] rx_bit;
	logic [CYC_W-1:0] rx_cyc;
	uart_byte_t rx_shift;
	logic rx_mid;

	// ********************
	// Transmitter
	// ********************

	assign tx_bit_end = tx_busy && (tx_cyc == CYC_W'(BIT_CYCLES - 1));
	assign tx_frame_end = tx_bit_end && (tx_bit == 4'd9);
	assign tx.ready = !tx_busy || tx_frame_end; // Next byte follows the stop bit directly.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx_busy <= 1'b0;
			tx_shift <= '1;
			tx_bit <= '0;
			tx_cyc <= '0;
			tx_done <= 1'b0;
		end else begin
			tx_done <= tx_frame_end && tx_last_q;
			if (tx.valid && tx.ready) begin
				tx_shift <= {1'b1, tx.data, 1'b0};
				tx_last_q <= tx.last;
				tx_busy <= 1'b1;
				tx_bit <= '0;
				tx_cyc <= '0;
			end else if (tx_bit_end) begin
				tx_cyc <= '0;
				tx_shift <= {1'b1, tx_shift[9:1]}; // Idle level fills in behind.
				tx_bit <= tx_bit + 1'b1;
				if (tx_bit == 4'd9)
					tx_busy <= 1'b0;
			end else if (tx_busy) begin
				tx_cyc <= tx_cyc + 1'b1;
			end
		end
	end

	// ********************
	// Channel multiplexing
	// ********************

	for (genvar i = 0; i < NUART; i++) begin : g_chan
		assign uart_out[i] = (channel == CH_W'(i)) ? tx_shift[0] : 1'b1;
		assign uart_en[i] = (channel == CH_W'(i)) ? !listen : 1'b1;
	end

	assign rx_in = listen ? uart_in[channel] : 1'b1;

	// ********************
	// Receiver
	// ********************

	assign rx_mid = (rx_cyc == CYC_W'(HALF));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_sync <= 2'b11;
			rx_busy <= 1'b0;
			rx_bit <= '0;
			rx_cyc <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx_in};
			rx_valid <= 1'b0;
			if (!listen) begin
				rx_busy <= 1'b0;
			end else if (!rx_busy) begin
				if (!rx_sync[1]) begin // Falling edge of a start bit.
					rx_busy <= 1'b1;
					rx_bit <= '0;
					rx_cyc <= '0;
				end
			end else begin
				rx_cyc <= (rx_cyc == CYC_W'(BIT_CYCLES - 1)) ? '0 : rx_cyc + 1'b1;
				if (rx_cyc == CYC_W'(BIT_CYCLES - 1))
					rx_bit <= rx_bit + 1'b1;
				if (rx_mid) begin
					if (rx_bit == 4'd0) begin
						if (rx_sync[1])
							rx_busy <= 1'b0; // Glitch, not a start bit.
					end else if (rx_bit == 4'd9) begin
						// The stop bit is not checked; a damaged byte fails the CRC.
						rx_byte <= rx_shift;
						rx_valid <= 1'b1;
						rx_busy <= 1'b0;
					end else begin
						rx_shift <= {rx_sync[1], rx_shift[7:1]};
					end
				end
			end
		end
	end

endmodule

/* logic/tmc_uart_top.sv */
`timescale 1ns/1ps

module tmc_uart_top #(
	parameter int CLK_HZ = 1000000,
	parameter int BAUD = 125000,
	parameter int NUART = 4,
	parameter int RX_TIMEOUT_BITS = 700,
	parameter int FIFO_DEPTH = 8,
	localparam int CH_W = uart_line_pkg::chan_bits(NUART)
) (
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	output logic cmd_ready,
	input tmc_proto_pkg::tmc_op_t cmd_op,
	input logic [CH_W-1:0] cmd_channel,
	input uart_line_pkg::uart_byte_t cmd_slave,
	input logic [6:0] cmd_register,
	input logic [31:0] cmd_data,
	output logic rsp_valid,
	input logic rsp_ready,
	output logic [CH_W-1:0] rsp_channel,
	output tmc_proto_pkg::tmc_status_t rsp_status,
	output logic [31:0] rsp_data,
	input logic [NUART-1:0] uart_in,
	output logic [NUART-1:0] uart_out,
	output logic [NUART-1:0] uart_en
);
	import uart_line_pkg::*;

	localparam int BIT_CYCLES = CLK_HZ / BAUD;

	byte_stream_if ctrl_to_fifo ();
	byte_stream_if fifo_to_line ();

	uart_byte_t rx_byte;
	logic rx_valid;
	logic tx_done;
	logic [CH_W-1:0] channel;
	logic listen;

	tmc_datagram_ctrl #(
		.NUART(NUART),
		.BIT_CYCLES(BIT_CYCLES),
		.RX_TIMEOUT_BITS(RX_TIMEOUT_BITS)
	) ctrl0 (
		.clk(clk), .rst_n(rst_n),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op),
		.cmd_channel(cmd_channel), .cmd_slave(cmd_slave),
		.cmd_register(cmd_register), .cmd_data(cmd_data),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_channel(rsp_channel),
		.rsp_status(rsp_status), .rsp_data(rsp_data),
		.tx(ctrl_to_fifo.source),
		.rx_byte(rx_byte), .rx_valid(rx_valid), .tx_done(tx_done),
		.channel(channel), .listen(listen)
	);

	byte_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) fifo0 (
		.clk(clk), .rst_n(rst_n),
		.in_s(ctrl_to_fifo.sink),
		.out_s(fifo_to_line.source)
	);

	uart_line #(
		.NUART(NUART),
		.BIT_CYCLES(BIT_CYCLES)
	) line0 (
		.clk(clk), .rst_n(rst_n),
		.tx(fifo_to_line.sink),
		.channel(channel), .listen(listen),
		.rx_byte(rx_byte), .rx_valid(rx_valid), .tx_done(tx_done),
		.uart_in(uart_in), .uart_out(uart_out), .uart_en(uart_en)
	);

endmodule

/* sim/tmc_uart_assertions.sv */
`timescale 1ns/1ps

module tmc_uart_assertions #(
	parameter int NUART = 4,
	localparam int CH_W = uart_line_pkg::chan_bits(NUART)
) (
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	input logic cmd_ready,
	input tmc_proto_pkg::tmc_op_t cmd_op,
	input logic [CH_W-1:0] cmd_channel,
	input uart_line_pkg::uart_byte_t cmd_slave,
	input logic [6:0] cmd_register,
	input logic [31:0] cmd_data,
	input logic rsp_valid,
	input logic rsp_ready,
	input logic [CH_W-1:0] rsp_channel,
	input tmc_proto_pkg::tmc_status_t rsp_status,
	input logic [31:0] rsp_data,
	input logic [NUART-1:0] uart_out,
	input logic [NUART-1:0] uart_en
);

	a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid && !cmd_ready |=> cmd_valid
			&& $stable({cmd_op, cmd_channel, cmd_slave, cmd_register, cmd_data}))
		else $error("Command fields changed while waiting for cmd_ready.");

	a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid
			&& $stable({rsp_channel, rsp_status, rsp_data}))
		else $error("Response fields changed while waiting for rsp_ready.");

	// Only the selected channel may release its driver.
	a_one_released: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(~uart_en) <= 1)
		else $error("More than one uart_en bit is low.");

	a_idle_line: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_ready |-> (uart_out == '1))
		else $error("A uart_out bit is low while a command can be accepted.");

endmodule

bind tmc_uart_top tmc_uart_assertions #(.NUART(NUART)) chk0 (
	.clk(clk), .rst_n(rst_n),
	.cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op),
	.cmd_channel(cmd_channel), .cmd_slave(cmd_slave),
	.cmd_register(cmd_register), .cmd_data(cmd_data),
	.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_channel(rsp_channel),
	.rsp_status(rsp_status), .rsp_data(rsp_data),
	.uart_out(uart_out), .uart_en(uart_en)
);

/* sim/tb_tmc_uart.sv */
`timescale 1ns/1ps

module tb_tmc_uart;
	import tmc_proto_pkg::*;
	import uart_line_pkg::*;

	localparam int CLK_HZ = 1000000;
	localparam int BAUD = 125000;
	localparam int NUART = 4;
	localparam int RX_TIMEOUT_BITS = 700;
	localparam int BIT_CYCLES = CLK_HZ / BAUD;
	localparam int NROWS = 7;
	localparam int LIMIT = NROWS * (RX_TIMEOUT_BITS + 120) * BIT_CYCLES;

	typedef enum int {REPLY_NONE, REPLY_GOOD, REPLY_BAD_CRC, REPLY_BAD_SYNC} reply_t;

	typedef struct {
		string name;
		logic [1:0] op;
		logic [1:0] chan;
		logic [7:0] slave;
		logic [6:0] regno;
		logic [31:0] data;
		reply_t reply;
		tmc_status_t status;
	} row_t;

	logic clk;
	logic rst_n;
	logic cmd_valid;
	logic cmd_ready;
	tmc_op_t cmd_op;
	logic [1:0] cmd_channel;
	uart_byte_t cmd_slave;
	logic [6:0] cmd_register;
	logic [31:0] cmd_data;
	logic rsp_valid;
	logic rsp_ready;
	logic [1:0] rsp_channel;
	tmc_status_t rsp_status;
	logic [31:0] rsp_data;
	logic [NUART-1:0] uart_in;
	logic [NUART-1:0] uart_out;
	logic [NUART-1:0] uart_en;

	row_t rows [NROWS];
	uart_byte_t line_q [$]; // Bytes seen on the active channel.
	uart_byte_t exp_q [$];
	string cur_name;
	logic [1:0] cur_ch;
	int errors;
	int cycles;
	int seed;
	int n;

	tmc_uart_top #(
		.CLK_HZ(CLK_HZ),
		.BAUD(BAUD),
		.NUART(NUART),
		.RX_TIMEOUT_BITS(RX_TIMEOUT_BITS)
	) dut0 (
		.clk(clk), .rst_n(rst_n),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op),
		.cmd_channel(cmd_channel), .cmd_slave(cmd_slave),
		.cmd_register(cmd_register), .cmd_data(cmd_data),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_channel(rsp_channel),
		.rsp_status(rsp_status), .rsp_data(rsp_data),
		.uart_in(uart_in), .uart_out(uart_out), .uart_en(uart_en)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// CRC-8, polynomial 0x07, each byte fed in LSB first.
	function automatic uart_byte_t crc8_update(input uart_byte_t crc, input uart_byte_t b);
		uart_byte_t c;
		logic fb;
		int i;
		c = crc;
		for (i = 0; i < 8; i++) begin
			fb = c[7] ^ b[i];
			c = c << 1;
			if (fb)
				c = c ^ 8'h07;
		end
		return c;
	endfunction

	// ********************
	// Driver-reply model
	// ********************

	task automatic send_byte(input logic [1:0] ch, input uart_byte_t b);
		logic [9:0] frame;
		int i;
		frame = {1'b1, b, 1'b0}; // Stop, data, start.
		for (i = 0; i < 10; i++) begin
			uart_in[ch] = frame[i];
			repeat (BIT_CYCLES) @(posedge clk);
			#1;
		end
	endtask

	task automatic send_reply(input row_t r, input logic [31:0] value);
		uart_byte_t rep [8];
		uart_byte_t crc;
		int i;
		@(negedge clk);
		while (uart_en[r.chan])
			@(negedge clk); // The master releases the line.
		repeat (BIT_CYCLES) @(posedge clk);
		#1;
		rep[0] = (r.reply == REPLY_BAD_SYNC) ? 8'h0a : 8'h05;
		rep[1] = 8'hff;
		rep[2] = {1'b0, r.regno};
		rep[3] = value[31:24];
		rep[4] = value[23:16];
		rep[5] = value[15:8];
		rep[6] = value[7:0];
		crc = 8'h00;
		for (i = 0; i < 7; i++)
			crc = crc8_update(crc, rep[i]);
		rep[7] = (r.reply == REPLY_BAD_CRC) ? ~crc : crc;
		for (i = 0; i < 8; i++)
			send_byte(r.chan, rep[i]);
	endtask

	// ********************
	// Line monitors
	// ********************

	// Decodes 8N1 bytes sent by the master on the active channel.
	always begin : line_decode
		uart_byte_t b;
		logic [1:0] ch;
		int k;
		@(negedge clk);
		ch = cur_ch;
		if (rst_n && uart_en[ch] && !uart_out[ch]) begin
			repeat (BIT_CYCLES / 2) @(negedge clk); // Middle of the start bit.
			if (!uart_out[ch]) begin
				for (k = 0; k < 8; k++) begin
					repeat (BIT_CYCLES) @(negedge clk);
					b[k] = uart_out[ch];
				end
				repeat (BIT_CYCLES) @(negedge clk);
				compare_value($sformatf("%s stop bit", cur_name), 1, uart_out[ch]);
				line_q.push_back(b);
			end
		end
	end

	always @(negedge clk) begin : idle_check
		int i;
		if (rst_n) begin
			for (i = 0; i < NUART; i++) begin
				if (i != int'(cur_ch)) begin
					compare_value($sformatf("%s uart_out[%0d] idle", cur_name, i), 1, uart_out[i]);
					compare_value($sformatf("%s uart_en[%0d] idle", cur_name, i), 1, uart_en[i]);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ********************
	// Command and response
	// ********************

	task automatic take_response(input row_t r, input logic [31:0] exp_data);
		logic [1:0] ch0;
		tmc_status_t st0;
		logic [31:0] d0;
		int hold;
		int i;
		@(negedge clk);
		while (!rsp_valid)
			@(negedge clk);
		ch0 = rsp_channel;
		st0 = rsp_status;
		d0 = rsp_data;
		hold = $random(seed) & 15; // Back-pressure on the response.
		for (i = 0; i < hold; i++) begin
			@(negedge clk);
			compare_value($sformatf("%s rsp_valid held", r.name), 1, rsp_valid);
			compare_value($sformatf("%s cmd_ready blocked", r.name), 0, cmd_ready);
			compare_value($sformatf("%s rsp_channel held", r.name), ch0, rsp_channel);
			compare_value($sformatf("%s rsp_status held", r.name), 32'(st0), 32'(rsp_status));
			compare_value($sformatf("%s rsp_data held", r.name), d0, rsp_data);
		end
		@(posedge clk);
		#1 rsp_ready = 1'b1;
		@(posedge clk);
		#1 rsp_ready = 1'b0;
		compare_value($sformatf("%s rsp_channel", r.name), r.chan, ch0);
		compare_value($sformatf("%s rsp_status", r.name), 32'(r.status), 32'(st0));
		if (r.reply == REPLY_GOOD)
			compare_value($sformatf("%s rsp_data", r.name), exp_data, d0);
	endtask

	task automatic run_row(input row_t r);
		logic [31:0] value;
		uart_byte_t crc;
		int i;
		value = $random(seed);
		@(negedge clk);
		while (!cmd_ready)
			@(negedge clk);
		cur_ch = r.chan;
		cur_name = r.name;
		line_q.delete();
		exp_q.delete();
		if (r.op == 2'd1 || r.op == 2'd2) begin
			exp_q.push_back(8'h05);
			exp_q.push_back(r.slave);
			exp_q.push_back({r.op == 2'd1, r.regno}); // Bit 7 marks a write.
			if (r.op == 2'd1) begin
				exp_q.push_back(r.data[31:24]);
				exp_q.push_back(r.data[23:16]);
				exp_q.push_back(r.data[15:8]);
				exp_q.push_back(r.data[7:0]);
			end
			crc = 8'h00;
			for (i = 0; i < exp_q.size(); i++)
				crc = crc8_update(crc, exp_q[i]);
			exp_q.push_back(crc);
		end
		@(posedge clk);
		#1;
		cmd_valid = 1'b1;
		cmd_op = tmc_op_t'(r.op);
		cmd_channel = r.chan;
		cmd_slave = r.slave;
		cmd_register = r.regno;
		cmd_data = r.data;
		@(posedge clk);
		#1 cmd_valid = 1'b0;
		fork
			begin
				if (r.op == 2'd2 && r.reply != REPLY_NONE)
					send_reply(r, value);
			end
			begin
				take_response(r, value);
			end
		join
		compare_value($sformatf("%s byte count", r.name), exp_q.size(), line_q.size());
		for (i = 0; i < exp_q.size() && i < line_q.size(); i++)
			compare_value($sformatf("%s byte %0d", r.name, i), exp_q[i], line_q[i]);
	endtask

	initial begin
		seed = 32'ha492;
		errors = 0;
		cycles = 0;
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_op = TMC_OP_WRITE;
		cmd_channel = '0;
		cmd_slave = '0;
		cmd_register = '0;
		cmd_data = '0;
		rsp_ready = 1'b0;
		uart_in = '1;
		cur_ch = '0;
		cur_name = "reset";

		rows[0] = '{"write_ch0", 2'd1, 2'd0, 8'h00, 7'h10, 32'h12345678, REPLY_NONE, ST_OK};
		rows[1] = '{"read_ch1_good", 2'd2, 2'd1, 8'h01, 7'h06, 32'h0, REPLY_GOOD, ST_OK};
		rows[2] = '{"read_ch2_bad_crc", 2'd2, 2'd2, 8'h02, 7'h6f, 32'h0, REPLY_BAD_CRC, ST_CRC};
		rows[3] = '{"read_ch3_bad_sync", 2'd2, 2'd3, 8'h03, 7'h01, 32'h0, REPLY_BAD_SYNC,
			ST_SYNC};
		rows[4] = '{"read_ch0_no_reply", 2'd2, 2'd0, 8'h00, 7'h22, 32'h0, REPLY_NONE, ST_TIMEOUT};
		rows[5] = '{"bad_opcode", 2'd3, 2'd1, 8'h01, 7'h10, 32'hdeadbeef, REPLY_NONE, ST_BAD_OP};
		rows[6] = '{"write_ch3", 2'd1, 2'd3, 8'h03, 7'h6c, 32'ha5c30f81, REPLY_NONE, ST_OK};

		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;

		for (n = 0; n < NROWS; n++)
			run_row(rows[n]);

		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* all.f */
logic/tmc_proto_pkg.sv
logic/uart_line_pkg.sv
logic/byte_stream_if.sv
logic/tmc_datagram_ctrl.sv
logic/byte_fifo.sv
logic/uart_line.sv
logic/tmc_uart_top.sv
sim/tmc_uart_assertions.sv
sim/tb_tmc_uart.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log.
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_tmc_uart -f all.f -o tb_tmc_uart \
	&& ./obj_dir/tb_tmc_uart > sim.log 2>&1 \
	|| echo "TEST RESULT: FAIL" >> sim.log
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
